// ==== design/axi4s_cfg.svh ====
// size macros: beat width, fifo depth, almost-full threshold, packet and store length

`ifndef AXI4S_CFG_SVH
`define AXI4S_CFG_SVH

// bytes per stream beat
`define AXI4S_DATA_BYTES 4

// egress fifo words
`define FIFO_DEPTH 32

// almost full once free words drop to this level
`define ALMOST_FULL_THRESH 4

// longest packet, in beats
`define MAX_PKT_LEN 8

// discard store holds three max-length packets
`define PKT_STORE_DEPTH (3 * `MAX_PKT_LEN)

`endif

// ==== design/axi4s_pkg.sv ====
// shared enums: discard stage state and stream probe mode

package axi4s_pkg;

   // ----------------------------------------
   // packet discard stage
   // ----------------------------------------

   // PASS  storing beats of the current packet
   // DROP  skipping the tail of a packet that did not fit
   typedef enum logic {
      PASS = 1'b0,
      DROP = 1'b1
   } pkt_state_t;

   // ----------------------------------------
   // stream probe
   // ----------------------------------------

   // PROBE_TRAFFIC  packets and bytes seen at ingress
   // PROBE_OVFL     packets dropped by the discard stage
   typedef enum logic {
      PROBE_TRAFFIC = 1'b0,
      PROBE_OVFL    = 1'b1
   } probe_mode_t;

endpackage : axi4s_pkg

// ==== design/fifo_sync.sv ====
// fifo_sync: first-word-fall-through synchronous fifo with occupancy count and overflow pulse

`timescale 1ns/100ps

module fifo_sync #(
   parameter int DATA_WID = 8,
   parameter int DEPTH    = 16
) (
   input  logic                         axi4s_out,   // clock
   input  logic                         rst,

   input  logic                         wr,
   input  logic [DATA_WID-1:0]          wr_data,

   input  logic                         rd,
   output logic [DATA_WID-1:0]          rd_data,     // valid whenever empty is low

   output logic [$clog2(DEPTH+1)-1:0]   count,
   output logic                         full,
   output logic                         empty,
   output logic                         oflow        // write attempted while full
);

   localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_WID = $clog2(DEPTH+1);

   logic [DATA_WID-1:0] mem [DEPTH];   // storage array
   logic [PTR_WID-1:0]  wr_ptr;
   logic [PTR_WID-1:0]  rd_ptr;
   logic                wr_ok;         // write actually taken
   logic                rd_ok;         // read actually taken

   // pointer step with wrap, depth need not be a power of two
   function automatic logic [PTR_WID-1:0] ptr_inc(input logic [PTR_WID-1:0] p);
      return (p == PTR_WID'(DEPTH-1)) ? '0 : p + 1'b1;
   endfunction

   assign full  = (count == CNT_WID'(DEPTH));
   assign empty = (count == '0);

   assign wr_ok = wr && !full;   // write while full is lost
   assign rd_ok = rd && !empty;  // read while empty is ignored

   // ----------------------------------------
   // storage, no reset on payload
   // ----------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (wr_ok) mem[wr_ptr] <= wr_data;
   end

   assign rd_data = mem[rd_ptr];  // fall-through read

   // ----------------------------------------
   // pointers, count, overflow flag
   // ----------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         oflow  <= 1'b0;
      end else begin
         if (wr_ok) wr_ptr <= ptr_inc(wr_ptr);
         if (rd_ok) rd_ptr <= ptr_inc(rd_ptr);

         // net occupancy change, simultaneous rd and wr cancel
         if (wr_ok && !rd_ok)      count <= count + 1'b1;
         else if (rd_ok && !wr_ok) count <= count - 1'b1;

         oflow <= wr && full;   // one-cycle pulse
      end
   end

endmodule : fifo_sync

// ==== design/axi4s_pkt_discard.sv ====
// axi4s_pkt_discard: ingress packet store that commits whole packets and drops overflowing ones

`timescale 1ns/100ps

`include "axi4s_cfg.svh"

module axi4s_pkt_discard
   import axi4s_pkg::*;
(
   input  logic                            axi4s_out,   // clock
   input  logic                            rst,

   // ingress, no back-pressure
   input  logic                            in_tvalid,
   input  logic [`AXI4S_DATA_BYTES*8-1:0]  in_tdata,
   input  logic [`AXI4S_DATA_BYTES-1:0]    in_tkeep,
   input  logic                            in_tlast,

   // committed packets toward the fifo
   output logic                            disc_tvalid,
   input  logic                            disc_tready,
   output logic [`AXI4S_DATA_BYTES*8-1:0]  disc_tdata,
   output logic [`AXI4S_DATA_BYTES-1:0]    disc_tkeep,
   output logic                            disc_tlast,

   output logic                            pkt_drop     // one pulse per dropped packet
);

   localparam int DEPTH    = `PKT_STORE_DEPTH;
   localparam int DATA_WID = `AXI4S_DATA_BYTES*8;
   localparam int WORD_WID = 1 + `AXI4S_DATA_BYTES + DATA_WID;   // {tlast, tkeep, tdata}
   localparam int PTR_WID  = $clog2(DEPTH);
   localparam int CNT_WID  = $clog2(DEPTH+1);

   logic [WORD_WID-1:0] mem [DEPTH];
   logic [PTR_WID-1:0]  wr_ptr;    // tentative, runs ahead inside a packet
   logic [PTR_WID-1:0]  cmt_ptr;   // one past the last committed tlast
   logic [PTR_WID-1:0]  rd_ptr;
   logic [CNT_WID-1:0]  used;      // words from rd_ptr to wr_ptr
   logic [CNT_WID-1:0]  pend;      // uncommitted words of current packet
   pkt_state_t          state;

   logic                store_full;
   logic                wr_ok;     // beat stored
   logic                drop_now;  // beat arrives with no room
   logic                rd_ok;     // word handed to the fifo

   function automatic logic [PTR_WID-1:0] ptr_inc(input logic [PTR_WID-1:0] p);
      return (p == PTR_WID'(DEPTH-1)) ? '0 : p + 1'b1;
   endfunction

   assign store_full = (used == CNT_WID'(DEPTH));
   assign wr_ok      = in_tvalid && (state == PASS) && !store_full;
   assign drop_now   = in_tvalid && (state == PASS) && store_full;
   assign rd_ok      = disc_tvalid && disc_tready;

   // ----------------------------------------
   // store, payload only
   // ----------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (wr_ok) mem[wr_ptr] <= {in_tlast, in_tkeep, in_tdata};
   end

   // read side never passes the committed point
   assign disc_tvalid = (used != pend);
   assign {disc_tlast, disc_tkeep, disc_tdata} = mem[rd_ptr];

   // ----------------------------------------
   // pointers and drop fsm
   // ----------------------------------------
   always_ff @(posedge axi4s_out) begin
      if (rst) begin
         wr_ptr   <= '0;
         cmt_ptr  <= '0;
         rd_ptr   <= '0;
         used     <= '0;
         pend     <= '0;
         state    <= PASS;
         pkt_drop <= 1'b0;
      end else begin
         pkt_drop <= drop_now;

         if (rd_ok) rd_ptr <= ptr_inc(rd_ptr);

         // occupancy: +write, -read, minus the rewound packet on a drop
         used <= used + CNT_WID'(wr_ok) - CNT_WID'(rd_ok) - (drop_now ? pend : '0);

         if (wr_ok) begin
            wr_ptr <= ptr_inc(wr_ptr);
            if (in_tlast) begin
               cmt_ptr <= ptr_inc(wr_ptr);   // whole packet now visible
               pend    <= '0;
            end else begin
               pend    <= pend + 1'b1;
            end
         end

         if (drop_now) begin
            wr_ptr <= cmt_ptr;   // discard the partial packet
            pend   <= '0;
            // a full store on the tlast beat ends the packet right here
            state  <= in_tlast ? PASS : DROP;
         end else if (state == DROP && in_tvalid && in_tlast) begin
            state  <= PASS;      // tail skipped, next packet starts clean
         end
      end
   end

endmodule : axi4s_pkt_discard

// ==== design/axi4s_probe.sv ====
// axi4s_probe: ingress stream probe counting packets and bytes, or dropped packets

`timescale 1ns/100ps

`include "axi4s_cfg.svh"

module axi4s_probe
   import axi4s_pkg::*;
#(
   parameter probe_mode_t MODE = PROBE_TRAFFIC
) (
   input  logic                          axi4s_out,   // clock
   input  logic                          rst,

   input  logic                          tvalid,
   input  logic [`AXI4S_DATA_BYTES-1:0]  tkeep,
   input  logic                          tlast,
   input  logic                          drop,        // drop pulse from discard stage

   output logic [31:0]                   pkt_cnt,
   output logic [31:0]                   byte_cnt
);

   // number of valid bytes in one beat
   function automatic logic [31:0] keep_bytes(input logic [`AXI4S_DATA_BYTES-1:0] k);
      logic [31:0] n;
      n = '0;
      for (int i = 0; i < `AXI4S_DATA_BYTES; i++) n = n + k[i];
      return n;
   endfunction

   generate
      if (MODE == PROBE_TRAFFIC) begin : g_traffic
         // ----------------------------------------
         // packets and bytes
         // ----------------------------------------
         always_ff @(posedge axi4s_out) begin
            if (rst) begin
               pkt_cnt  <= '0;
               byte_cnt <= '0;
            end else if (tvalid) begin
               if (tlast) pkt_cnt <= pkt_cnt + 1'b1;   // one per packet end
               byte_cnt <= byte_cnt + keep_bytes(tkeep);
            end
         end
      end else begin : g_ovfl
         // dropped packets only, byte count unused
         always_ff @(posedge axi4s_out) begin
            if (rst)       pkt_cnt <= '0;
            else if (drop) pkt_cnt <= pkt_cnt + 1'b1;
         end
         assign byte_cnt = '0;
      end
   endgenerate

endmodule : axi4s_probe

// ==== design/axi4s_pkt_fifo_sync.sv ====
// axi4s_pkt_fifo_sync: packet fifo joining discard stage, egress fifo and store-and-forward gate

`timescale 1ns/100ps

`include "axi4s_cfg.svh"

module axi4s_pkt_fifo_sync #(
   parameter bit STR_FWD_MODE = 1'b0   // 1: hold out_tvalid until a whole packet is in
) (
   input  logic                            axi4s_out,   // clock
   input  logic                            rst,

   // ingress, no back-pressure
   input  logic                            in_tvalid,
   input  logic [`AXI4S_DATA_BYTES*8-1:0]  in_tdata,
   input  logic [`AXI4S_DATA_BYTES-1:0]    in_tkeep,
   input  logic                            in_tlast,

   // egress
   output logic                            out_tvalid,
   input  logic                            out_tready,
   output logic [`AXI4S_DATA_BYTES*8-1:0]  out_tdata,
   output logic [`AXI4S_DATA_BYTES-1:0]    out_tkeep,
   output logic                            out_tlast,

   output logic                            pkt_drop,
   output logic                            oflow
);

   localparam int DATA_WID = `AXI4S_DATA_BYTES*8;
   localparam int WORD_WID = 1 + `AXI4S_DATA_BYTES + DATA_WID;   // {tlast, tkeep, tdata}
   localparam int CNT_WID  = $clog2(`FIFO_DEPTH+1);

   // discard stage to fifo
   logic                            disc_tvalid;
   logic                            disc_tready;
   logic [DATA_WID-1:0]             disc_tdata;
   logic [`AXI4S_DATA_BYTES-1:0]    disc_tkeep;
   logic                            disc_tlast;

   // fifo side
   logic                wr;
   logic [WORD_WID-1:0] wr_data;
   logic                rd;
   logic [WORD_WID-1:0] rd_data;
   logic [CNT_WID-1:0]  count;
   logic                fifo_empty;   // raw fifo empty
   logic                empty;        // empty seen by egress
   logic                almost_full;

   axi4s_pkt_discard pkt_discard_i (
      .axi4s_out   (axi4s_out),
      .rst         (rst),
      .in_tvalid   (in_tvalid),
      .in_tdata    (in_tdata),
      .in_tkeep    (in_tkeep),
      .in_tlast    (in_tlast),
      .disc_tvalid (disc_tvalid),
      .disc_tready (disc_tready),
      .disc_tdata  (disc_tdata),
      .disc_tkeep  (disc_tkeep),
      .disc_tlast  (disc_tlast),
      .pkt_drop    (pkt_drop)
   );

   // stop the discard stage a few words early, fifo never fills
   assign almost_full = (count >= CNT_WID'(`FIFO_DEPTH - `ALMOST_FULL_THRESH));
   assign disc_tready = !almost_full;

   assign wr      = disc_tvalid && disc_tready;
   assign wr_data = {disc_tlast, disc_tkeep, disc_tdata};
   assign rd      = out_tvalid && out_tready;

   fifo_sync #(
      .DATA_WID (WORD_WID),
      .DEPTH    (`FIFO_DEPTH)
   ) fifo_sync_i (
      .axi4s_out (axi4s_out),
      .rst       (rst),
      .wr        (wr),
      .wr_data   (wr_data),
      .rd        (rd),
      .rd_data   (rd_data),
      .count     (count),
      .full      (),
      .empty     (fifo_empty),
      .oflow     (oflow)
   );

   // ----------------------------------------
   // store-and-forward gate
   // ----------------------------------------
   generate
      if (STR_FWD_MODE) begin : g_str_fwd
         logic [CNT_WID-1:0] wr_tlast_cnt;   // packet ends written
         logic [CNT_WID-1:0] rd_tlast_cnt;   // packet ends read out

         always_ff @(posedge axi4s_out) begin
            if (rst) begin
               wr_tlast_cnt <= '0;
               rd_tlast_cnt <= '0;
            end else begin
               if (wr && disc_tlast) wr_tlast_cnt <= wr_tlast_cnt + 1'b1;
               if (rd && out_tlast)  rd_tlast_cnt <= rd_tlast_cnt + 1'b1;
            end
         end

         // no whole packet inside, report empty
         assign empty = fifo_empty || (wr_tlast_cnt == rd_tlast_cnt);
      end else begin : g_cut_through
         assign empty = fifo_empty;
      end
   endgenerate

   assign out_tvalid = !empty;
   assign {out_tlast, out_tkeep, out_tdata} = rd_data;

endmodule : axi4s_pkt_fifo_sync

// ==== design/axi4s_pkt_buffer_top.sv ====
// axi4s_pkt_buffer_top: packet buffer with ingress traffic probe and drop probe

`timescale 1ns/100ps

`include "axi4s_cfg.svh"

module axi4s_pkt_buffer_top
   import axi4s_pkg::*;
(
   input  logic                            axi4s_out,   // clock
   input  logic                            rst,

   input  logic                            in_tvalid,
   input  logic [`AXI4S_DATA_BYTES*8-1:0]  in_tdata,
   input  logic [`AXI4S_DATA_BYTES-1:0]    in_tkeep,
   input  logic                            in_tlast,

   output logic                            out_tvalid,
   input  logic                            out_tready,
   output logic [`AXI4S_DATA_BYTES*8-1:0]  out_tdata,
   output logic [`AXI4S_DATA_BYTES-1:0]    out_tkeep,
   output logic                            out_tlast,

   output logic                            oflow,
   output logic [31:0]                     pkt_cnt,    // ingress packets
   output logic [31:0]                     byte_cnt,   // ingress bytes
   output logic [31:0]                     drop_cnt    // dropped packets
);

   logic pkt_drop;   // discard stage drop pulse

   axi4s_pkt_fifo_sync #(.STR_FWD_MODE(1'b1)) pkt_fifo_i (
      .axi4s_out (axi4s_out),  .rst        (rst),
      .in_tvalid (in_tvalid),  .in_tdata   (in_tdata),
      .in_tkeep  (in_tkeep),   .in_tlast   (in_tlast),
      .out_tvalid(out_tvalid), .out_tready (out_tready),
      .out_tdata (out_tdata),  .out_tkeep  (out_tkeep),
      .out_tlast (out_tlast),  .pkt_drop   (pkt_drop),
      .oflow     (oflow)
   );

   // traffic seen at ingress, before any drop
   axi4s_probe #(.MODE(PROBE_TRAFFIC)) probe_traffic_i (
      .axi4s_out (axi4s_out), .rst (rst),
      .tvalid (in_tvalid), .tkeep (in_tkeep), .tlast (in_tlast), .drop (pkt_drop),
      .pkt_cnt (pkt_cnt), .byte_cnt (byte_cnt)
   );

   axi4s_probe #(.MODE(PROBE_OVFL)) probe_ovfl_i (
      .axi4s_out (axi4s_out), .rst (rst),
      .tvalid (in_tvalid), .tkeep (in_tkeep), .tlast (in_tlast), .drop (pkt_drop),
      .pkt_cnt (drop_cnt), .byte_cnt ()   // byte count held at zero here
   );

endmodule : axi4s_pkt_buffer_top

// ==== sim/axi4s_pkt_buffer_tb.sv ====
// testbench: clock, reset, packet stimulus, reference queue, assertions, watchdog and report

`timescale 1ns/100ps

`include "axi4s_cfg.svh"

module axi4s_pkt_buffer_tb;

   localparam int N_MIXED   = 40;                  // mixed traffic, egress mostly ready
   localparam int N_BURST   = 12;                  // max-length burst, egress stalled
   localparam int NUM_PKTS  = N_MIXED + N_BURST;
   localparam int WD_CYCLES = NUM_PKTS * `MAX_PKT_LEN * 4 + 2000;
   localparam int DW        = `AXI4S_DATA_BYTES * 8;
   localparam int KW        = `AXI4S_DATA_BYTES;

   logic          axi4s_out;
   logic          rst;
   logic          in_tvalid;
   logic [DW-1:0] in_tdata;
   logic [KW-1:0] in_tkeep;
   logic          in_tlast;
   logic          out_tvalid;
   logic          out_tready;
   logic [DW-1:0] out_tdata;
   logic [KW-1:0] out_tkeep;
   logic          out_tlast;
   logic          oflow;
   logic [31:0]   pkt_cnt;
   logic [31:0]   byte_cnt;
   logic [31:0]   drop_cnt;

   // reference packets, indexed by packet id
   logic [DW-1:0] ref_data [NUM_PKTS][`MAX_PKT_LEN];
   logic [KW-1:0] ref_keep [NUM_PKTS][`MAX_PKT_LEN];
   int            ref_len  [NUM_PKTS];
   int            sent_q [$];            // ids of fully driven packets, oldest first

   int            errors;
   int            cyc;
   int            sent_done;             // tlast beats seen at ingress
   int            rcv_pkts;              // whole packets taken at egress
   int            skipped;               // sent packets never seen at egress
   int            cur_id;
   int            beat_idx;
   logic [31:0]   exp_bytes;
   logic          hold_ready;            // stall egress completely
   logic [15:0]   ready_pat;             // out_tready pattern, rotated
   logic [3:0]    rdy_idx;
   logic          hold_chk;
   logic [DW+KW:0] hold_word;            // {tlast, tkeep, tdata} under back-pressure
   string         test_name;

   axi4s_pkt_buffer_top axi4s_pkt_buffer_top_i (.*);

   initial begin
      axi4s_out = 1'b0;
      forever #20 axi4s_out = ~axi4s_out;   // 40 ns period
   end

   // ----------------------------------------
   // drivers and counters
   // ----------------------------------------
   always @(posedge axi4s_out) begin
      cyc <= cyc + 1;
      rdy_idx <= rst ? 4'd0 : rdy_idx + 1'b1;
      out_tready <= hold_ready ? 1'b0 : ready_pat[rdy_idx];
      if (rst) sent_done <= 0;
      else if (in_tvalid && in_tlast) sent_done <= sent_done + 1;
   end

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge axi4s_out);
         in_tvalid <= 1'b0;
         in_tlast  <= 1'b0;
      end
   endtask

   // one packet, packet id rides in the top byte of its first beat
   task automatic send_pkt(input int id, input int len, input int gap);
      logic [DW-1:0] d;
      logic [KW-1:0] k;
      ref_len[id] = len;
      for (int b = 0; b < len; b++) begin
         d = $urandom;
         if (b == 0) d[DW-1:DW-8] = id[7:0];
         k = (b == len - 1) ? KW'((1 << $urandom_range(KW, 1)) - 1) : '1;
         ref_data[id][b] = d;
         ref_keep[id][b] = k;
         exp_bytes += $countones(k);
         @(posedge axi4s_out);
         in_tvalid <= 1'b1;
         in_tdata  <= d;
         in_tkeep  <= k;
         in_tlast  <= (b == len - 1);
      end
      sent_q.push_back(id);
      idle(gap);
   endtask

   // wait until every packet is received or dropped, then leave room for strays
   task automatic wait_drain(input int total);
      while (rcv_pkts + int'(drop_cnt) < total) @(posedge axi4s_out);
      repeat (`MAX_PKT_LEN * 4) @(posedge axi4s_out);
   endtask

   // ----------------------------------------
   // assertions
   // ----------------------------------------
   assert property (@(posedge axi4s_out) (cyc > 0 && $past(rst)) |->
      (!out_tvalid && !oflow && pkt_cnt == 0 && byte_cnt == 0 && drop_cnt == 0))
   else begin
      errors++;
      $display("[ERROR] reset: expected tvalid/oflow/pkt/byte/drop 0/0/0/0/0, actual %b/%b/%0d/%0d/%0d",
               $sampled(out_tvalid), $sampled(oflow), $sampled(pkt_cnt),
               $sampled(byte_cnt), $sampled(drop_cnt));
   end

   // store-and-forward: valid only with a whole packet still owed to egress
   assert property (@(posedge axi4s_out) disable iff (rst) out_tvalid |-> (sent_done > rcv_pkts))
   else begin
      errors++;
      $display("[ERROR] store_fwd: expected out_tvalid 0, actual 1 (sent %0d, received %0d)",
               $sampled(sent_done), $sampled(rcv_pkts));
   end

   assert property (@(posedge axi4s_out) disable iff (rst) !oflow)
   else begin
      errors++;
      $display("[ERROR] %s: expected oflow 0, actual 1", test_name);
   end

   // ----------------------------------------
   // egress monitor
   // ----------------------------------------
   task automatic check_beat(input int id, input int idx);
      if (idx >= ref_len[id]) begin
         errors++;
         $display("%s: packet %0d came out longer than the %0d beats sent",
                  test_name, id, ref_len[id]);
         return;
      end
      assert ({out_tlast, out_tkeep, out_tdata} ==
              {idx == ref_len[id] - 1, ref_keep[id][idx], ref_data[id][idx]})
      else begin
         errors++;
         $display("[ERROR] %s: pkt %0d beat %0d expected last/keep/data %b/%h/%h, actual %b/%h/%h",
                  test_name, id, idx, idx == ref_len[id] - 1, ref_keep[id][idx],
                  ref_data[id][idx], out_tlast, out_tkeep, out_tdata);
      end
   endtask

   always @(posedge axi4s_out) begin
      if (hold_chk) begin   // held beat must not move
         assert (out_tvalid && {out_tlast, out_tkeep, out_tdata} == hold_word)
         else begin
            errors++;
            $display("[ERROR] backpressure: expected held 1/%h, actual %b/%h", hold_word,
                     out_tvalid, {out_tlast, out_tkeep, out_tdata});
         end
      end
      hold_chk  = !rst && out_tvalid && !out_tready;
      hold_word = {out_tlast, out_tkeep, out_tdata};
      if (!rst && out_tvalid && out_tready) begin
         if (beat_idx == 0) begin
            cur_id = int'(out_tdata[DW-1:DW-8]);
            while (sent_q.size() > 0 && sent_q[0] != cur_id) begin
               void'(sent_q.pop_front());   // overtaken, so dropped at ingress
               skipped++;
            end
            if (sent_q.size() == 0) begin
               errors++;
               $display("%s: packet id %0d is out of order or was never sent", test_name, cur_id);
               cur_id = -1;
            end else begin
               void'(sent_q.pop_front());
            end
         end
         if (cur_id >= 0) check_beat(cur_id, beat_idx);
         if (out_tlast) begin
            beat_idx = 0;
            rcv_pkts <= rcv_pkts + 1;
         end else begin
            beat_idx++;
         end
      end
   end

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin
      int drops_before;
      void'($urandom(32'he9b50cc8));
      rst = 1'b1;
      in_tvalid = 1'b0;
      in_tdata = '0;
      in_tkeep = '0;
      in_tlast = 1'b0;
      out_tready = 1'b0;
      hold_ready = 1'b1;
      ready_pat = '1;
      exp_bytes = '0;
      test_name = "reset";
      repeat (4) @(posedge axi4s_out);
      rst <= 1'b0;
      idle(4);

      test_name = "integrity";
      hold_ready <= 1'b0;
      for (int p = 0; p < N_MIXED; p++) begin
         ready_pat <= 16'($urandom) | 16'($urandom);   // about 3 in 4 ready
         send_pkt(p, $urandom_range(`MAX_PKT_LEN, 1), $urandom_range(3, 0));
      end
      idle(1);
      wait_drain(N_MIXED);

      test_name = "overflow";
      drops_before = drop_cnt;
      hold_ready <= 1'b1;
      for (int p = N_MIXED; p < NUM_PKTS; p++) send_pkt(p, `MAX_PKT_LEN, 0);
      idle(4);
      assert (drop_cnt > drops_before)
      else begin
         errors++;
         $display("[ERROR] overflow: expected drop_cnt above %0d, actual %0d", drops_before, drop_cnt);
      end
      hold_ready <= 1'b0;
      wait_drain(NUM_PKTS);
      assert (rcv_pkts + int'(drop_cnt) == NUM_PKTS && skipped + sent_q.size() == drop_cnt)
      else begin
         errors++;
         $display("[ERROR] overflow: expected received+dropped %0d and missing %0d, actual %0d and %0d",
                  NUM_PKTS, drop_cnt, rcv_pkts + int'(drop_cnt), skipped + sent_q.size());
      end

      test_name = "probe";
      assert (pkt_cnt == NUM_PKTS)
      else begin
         errors++;
         $display("[ERROR] probe: expected pkt_cnt %0d, actual %0d", NUM_PKTS, pkt_cnt);
      end
      assert (byte_cnt == exp_bytes)
      else begin
         errors++;
         $display("[ERROR] probe: expected byte_cnt %0d, actual %0d", exp_bytes, byte_cnt);
      end

      $display("errors %0d, sent %0d, received %0d, dropped %0d",
               errors, NUM_PKTS, rcv_pkts, drop_cnt);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // watchdog, four cycles per possible beat plus drain margin
   initial begin
      repeat (WD_CYCLES) @(posedge axi4s_out);
      $display("watchdog: run did not finish within %0d cycles, %0d errors", WD_CYCLES, errors);
      $display("Done: errors found");
      $finish;
   end

endmodule : axi4s_pkt_buffer_tb

// ==== flist.f ====
+incdir+design
design/axi4s_pkg.sv
design/fifo_sync.sv
design/axi4s_pkt_discard.sv
design/axi4s_probe.sv
design/axi4s_pkt_fifo_sync.sv
design/axi4s_pkt_buffer_top.sv
sim/axi4s_pkt_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: axi4s_pkt_buffer

export_include_dirs:
  - design

sources:
  - files:
      - design/axi4s_pkg.sv
      - design/fifo_sync.sv
      - design/axi4s_pkt_discard.sv
      - design/axi4s_probe.sv
      - design/axi4s_pkt_fifo_sync.sv
      - design/axi4s_pkt_buffer_top.sv
  - target: simulation
    files:
      - sim/axi4s_pkt_buffer_tb.sv
